// ==== hw/obj_pkg.sv ====
// Object subsystem widths, sprite height, attribute and hit structs, scan phase enum
package obj_pkg;

    // Counter and bus widths
    localparam int line_w = 8;        // Line counter
    localparam int idx_w  = 5;        // Object number, 32 entries
    localparam int pxl_w  = 4;        // Pixel count within one object slot
    localparam int ram_aw = 7;        // 128 byte object RAM

    // Sprite height in lines
    localparam int obj_h = 16;

    // Who owns the object RAM
    typedef enum logic {
        active = 1'b0,                // Scan reads the RAM
        vblank = 1'b1                 // CPU may write the RAM
    } scan_phase_e;

    // One RAM entry as assembled by the scan
    typedef struct packed {
        logic [7:0] code;             // Tile number
        logic [7:0] attr;             // Bit 7 hflip, bits 3..0 colour
        logic [7:0] y;                // Top line
        logic [7:0] x;                // Left column
    } obj_attr_t;

    // Object that covers the current line
    typedef struct packed {
        logic [7:0]       code;
        logic [3:0]       row;        // Line inside the sprite
        logic [7:0]       x;
        logic             flip;
        logic [3:0]       colour;
        logic [idx_w-1:0] index;      // Entry number 0..31
    } obj_hit_t;

endpackage

// ==== hw/obj_timing.sv ====
// Pixel clock enables, pixel/object/line counters, blanking phase and line start strobe
`timescale 1ns/100ps

module obj_timing #(
    parameter int lines_per_frame = 64,
    parameter int vblank_start    = 48
) (
    input  logic                       clk,
    input  logic                       rst,
    output logic                       cen6,
    output logic                       cen3,
    output logic [obj_pkg::pxl_w-1:0]  pxlcnt,
    output logic [obj_pkg::idx_w-1:0]  objcnt,
    output logic [obj_pkg::line_w-1:0] line,
    output obj_pkg::scan_phase_e       phase,
    output logic                       line_start
);
    import obj_pkg::*;

    localparam logic [line_w-1:0] last_line = line_w'(lines_per_frame - 1);
    localparam logic [line_w-1:0] vb_line   = line_w'(vblank_start);

    logic [1:0] cen_cnt;              // clk divider

    // cen6 on every second clk, cen3 on every fourth
    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt <= 2'd0;
            cen6    <= 1'b0;
            cen3    <= 1'b0;
        end else begin
            cen_cnt <= cen_cnt + 2'd1;
            cen6    <= cen_cnt[0];    // Odd counts
            cen3    <= &cen_cnt;      // Count 3 only, so always with cen6
        end
    end

    // Nested counters, one object slot is 16 pixels
    always_ff @(posedge clk) begin
        if (rst) begin
            pxlcnt     <= '0;
            objcnt     <= '0;
            line       <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (cen6) begin
                pxlcnt <= pxlcnt + 1'b1;
                if (&pxlcnt) begin
                    objcnt <= objcnt + 1'b1;
                    if (&objcnt) begin
                        // Last slot of the line
                        line_start <= 1'b1;   // High while new line is shown
                        if (line == last_line)
                            line <= '0;
                        else
                            line <= line + 1'b1;
                    end
                end
            end
        end
    end

    // CPU window covers the lines at and past vblank_start
    always_comb begin
        if (line >= vb_line)
            phase = vblank;
        else
            phase = active;
    end

endmodule

// ==== hw/obj_ram.sv ====
// Single-port 128x8 synchronous RAM with clock enable
`timescale 1ns/100ps

module obj_ram (
    input  logic                       clk,
    input  logic                       cen,
    input  logic [obj_pkg::ram_aw-1:0] addr,
    input  logic [7:0]                 data,
    input  logic                       we,
    output logic [7:0]                 q
);

    logic [7:0] mem [0:(1 << obj_pkg::ram_aw) - 1];

    // Read returns the old byte on a write cycle
    always_ff @(posedge clk) begin
        if (cen) begin
            if (we)
                mem[addr] <= data;
            q <= mem[addr];
        end
    end

endmodule

// ==== hw/obj_attr_fetch.sv ====
// Object RAM ownership mux, byte collector and attribute word latch
`timescale 1ns/100ps

module obj_attr_fetch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cen6,
    input  logic                       cen3,
    input  logic [obj_pkg::pxl_w-1:0]  pxlcnt,
    input  logic [obj_pkg::idx_w-1:0]  objcnt,
    input  obj_pkg::scan_phase_e       phase,
    input  logic [obj_pkg::ram_aw-1:0] cpu_addr,
    input  logic [7:0]                 cpu_data,
    input  logic                       cpu_we,
    output obj_pkg::obj_attr_t         attr,
    output logic [obj_pkg::idx_w-1:0]  attr_index,
    output logic                       attr_valid
);
    import obj_pkg::*;

    logic [ram_aw-1:0] scan_addr;
    logic [ram_aw-1:0] ram_addr;
    logic              ram_we;
    logic              ram_cen;
    logic [7:0]        ram_q;
    logic [31:0]       collect;       // Last four bytes, oldest on top
    logic              latch;

    // CPU owns the RAM in vblank, scan owns it otherwise
    always_comb begin
        scan_addr = {objcnt, pxlcnt[1:0]};   // Byte offset from pixel count
        if (phase == vblank) begin
            ram_addr = cpu_addr;
            ram_we   = cpu_we;
        end else begin
            ram_addr = scan_addr;
            ram_we   = 1'b0;          // CPU writes dropped while scanning
        end
    end

    // A CPU strobe writes at once, reads follow the pixel rate
    assign ram_cen = cen6 | ram_we;

    obj_ram u_ram (
        .clk  (clk),
        .cen  (ram_cen),
        .addr (ram_addr),
        .data (cpu_data),
        .we   (ram_we),
        .q    (ram_q)
    );

    // One byte in per pixel
    always_ff @(posedge clk) begin
        if (cen6)
            collect <= {collect[23:0], ram_q};
    end

    // At pixel 6 the collector holds offsets 1,2,3,0 of this object
    // This edge falls between two cen3 edges
    assign latch = cen6 && !cen3 && (phase == active) && (pxlcnt == 4'd6);

    always_ff @(posedge clk) begin
        if (latch) begin
            attr.x     <= collect[7:0];     // Offset 0
            attr.y     <= collect[31:24];   // Offset 1
            attr.code  <= collect[23:16];   // Offset 2
            attr.attr  <= collect[15:8];    // Offset 3
            attr_index <= objcnt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            attr_valid <= 1'b0;
        else
            attr_valid <= latch;      // One clk per object per line
    end

endmodule

// ==== hw/obj_ctrl_regs.sv ====
// CPU control registers for object enable and vertical offset
`timescale 1ns/100ps

module obj_ctrl_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 cpu_addr,
    input  logic [7:0]                 cpu_data,
    input  logic                       cpu_we,
    output logic                       obj_en,
    output logic [obj_pkg::line_w-1:0] y_off
);

    localparam logic [7:0] addr_en   = 8'h80;
    localparam logic [7:0] addr_yoff = 8'h81;

    logic wr_en;
    logic wr_yoff;

    // Register decode, bit 7 set selects this block
    assign wr_en   = cpu_we && (cpu_addr == addr_en);
    assign wr_yoff = cpu_we && (cpu_addr == addr_yoff);

    // Accepted in any phase
    always_ff @(posedge clk) begin
        if (rst) begin
            obj_en <= 1'b0;
            y_off  <= '0;
        end else begin
            if (wr_en)
                obj_en <= cpu_data[0];
            if (wr_yoff)
                y_off <= cpu_data;    // Added to line before the range test
        end
    end

endmodule

// ==== hw/obj_line_match.sv ====
// Two-stage line matcher with vertical range test, per-line hit limit and overflow
`timescale 1ns/100ps

module obj_line_match #(
    parameter int max_per_line = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [obj_pkg::line_w-1:0] line,
    input  logic                       line_start,
    input  obj_pkg::obj_attr_t         attr,
    input  logic [obj_pkg::idx_w-1:0]  attr_index,
    input  logic                       attr_valid,
    input  logic                       obj_en,
    input  logic [obj_pkg::line_w-1:0] y_off,
    output obj_pkg::obj_hit_t          hit,
    output logic                       hit_valid,
    output logic [3:0]                 hit_count,
    output logic                       overflow
);
    import obj_pkg::*;

    localparam logic [3:0] limit = 4'(max_per_line);

    logic [line_w-1:0] diff;          // Line inside the sprite, mod 256
    logic              in_range;
    logic              s1_hit;
    obj_attr_t         s1_attr;
    logic [3:0]        s1_row;
    logic [idx_w-1:0]  s1_index;
    logic              accept;

    // Stage 1, range test
    assign diff     = line + y_off - attr.y;
    assign in_range = diff < obj_h;

    always_ff @(posedge clk) begin
        if (rst)
            s1_hit <= 1'b0;
        else
            s1_hit <= attr_valid && obj_en && in_range;
    end

    always_ff @(posedge clk) begin
        if (attr_valid) begin
            s1_attr  <= attr;
            s1_row   <= diff[3:0];
            s1_index <= attr_index;
        end
    end

    // Stage 2, limit check
    assign accept = s1_hit && (hit_count < limit);

    always_ff @(posedge clk) begin
        if (accept) begin
            hit.code   <= s1_attr.code;
            hit.row    <= s1_row;
            hit.x      <= s1_attr.x;
            hit.flip   <= s1_attr.attr[7];
            hit.colour <= s1_attr.attr[3:0];
            hit.index  <= s1_index;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_valid <= 1'b0;
            hit_count <= 4'd0;
            overflow  <= 1'b0;
        end else begin
            hit_valid <= 1'b0;
            if (line_start) begin
                hit_count <= 4'd0;    // New line, fresh budget
                overflow  <= 1'b0;
            end else if (accept) begin
                hit_valid <= 1'b1;
                hit_count <= hit_count + 4'd1;
            end else if (s1_hit) begin
                overflow <= 1'b1;     // Held until the next line
            end
        end
    end

endmodule

// ==== hw/obj_top.sv ====
// Object subsystem top with timing, attribute fetch, control registers and line matcher
`timescale 1ns/100ps

module obj_top #(
    parameter int lines_per_frame = 64,
    parameter int vblank_start    = 48,
    parameter int max_per_line    = 8
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [7:0]                 cpu_addr,
    input  logic [7:0]                 cpu_data,
    input  logic                       cpu_we,
    output logic [obj_pkg::line_w-1:0] line,
    output obj_pkg::scan_phase_e       phase,
    output obj_pkg::obj_hit_t          hit,
    output logic                       hit_valid,
    output logic [3:0]                 hit_count,
    output logic                       overflow
);
    import obj_pkg::*;

    logic              cen6;
    logic              cen3;
    logic [pxl_w-1:0]  pxlcnt;
    logic [idx_w-1:0]  objcnt;
    logic              line_start;
    logic              ram_cpu_we;    // Write strobe for the RAM half of the map
    obj_attr_t         attr;
    logic [idx_w-1:0]  attr_index;
    logic              attr_valid;
    logic              obj_en;
    logic [line_w-1:0] y_off;

    assign ram_cpu_we = cpu_we & ~cpu_addr[7];

    obj_timing #(
        .lines_per_frame (lines_per_frame),
        .vblank_start    (vblank_start)
    ) u_timing (
        .clk        (clk),
        .rst        (rst),
        .cen6       (cen6),
        .cen3       (cen3),
        .pxlcnt     (pxlcnt),
        .objcnt     (objcnt),
        .line       (line),
        .phase      (phase),
        .line_start (line_start)
    );

    obj_attr_fetch u_fetch (
        .clk        (clk),
        .rst        (rst),
        .cen6       (cen6),
        .cen3       (cen3),
        .pxlcnt     (pxlcnt),
        .objcnt     (objcnt),
        .phase      (phase),
        .cpu_addr   (cpu_addr[ram_aw-1:0]),
        .cpu_data   (cpu_data),
        .cpu_we     (ram_cpu_we),
        .attr       (attr),
        .attr_index (attr_index),
        .attr_valid (attr_valid)
    );

    obj_ctrl_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .cpu_we   (cpu_we),
        .obj_en   (obj_en),
        .y_off    (y_off)
    );

    obj_line_match #(
        .max_per_line (max_per_line)
    ) u_match (
        .clk        (clk),
        .rst        (rst),
        .line       (line),
        .line_start (line_start),
        .attr       (attr),
        .attr_index (attr_index),
        .attr_valid (attr_valid),
        .obj_en     (obj_en),
        .y_off      (y_off),
        .hit        (hit),
        .hit_valid  (hit_valid),
        .hit_count  (hit_count),
        .overflow   (overflow)
    );

endmodule

// ==== tb/obj_tb.sv ====
// Testbench for obj_top with stimulus table, line hit model and typed compare tasks
`timescale 1ns/100ps

module obj_tb;
    import obj_pkg::*;

    localparam int n_case          = 8;
    localparam int lines_per_frame = 64;
    localparam int vblank_start    = 48;
    localparam int max_per_line    = 8;
    localparam int line_clks       = 1024;                     // 512 cen6 periods
    localparam int frame_clks      = lines_per_frame * line_clks;

    typedef struct packed {
        logic       en;               // Object enable register
        logic [7:0] y_off;
        logic       active_wr;        // Scribble the RAM during active lines
        logic       rnd;              // Entries from the random stream
    } case_t;

    logic              clk;
    logic              rst;
    logic [7:0]        cpu_addr;
    logic [7:0]        cpu_data;
    logic              cpu_we;
    logic [line_w-1:0] line;
    scan_phase_e       phase;
    obj_hit_t          hit;
    logic              hit_valid;
    logic [3:0]        hit_count;
    logic              overflow;

    case_t     case_tab [n_case];
    obj_attr_t ent_tab  [n_case][32];
    obj_hit_t  exp_q [$];             // Expected hits of one line, in order
    logic      exp_ovf;
    integer    seed;
    int        hit_errs;
    int        count_errs;
    int        flag_errs;
    int        line_errs;
    bit        timed_out;

    obj_top #(
        .lines_per_frame (lines_per_frame),
        .vblank_start    (vblank_start),
        .max_per_line    (max_per_line)
    ) u_obj_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_data  (cpu_data),
        .cpu_we    (cpu_we),
        .line      (line),
        .phase     (phase),
        .hit       (hit),
        .hit_valid (hit_valid),
        .hit_count (hit_count),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;       // 100 ns period
    end

    task automatic check_hit(input string name, input obj_hit_t exp, input obj_hit_t got);
        if (exp !== got) begin
            hit_errs++;
            $display("ERR %0t %s expected %h actual %h", $time, name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input logic [3:0] exp, input logic [3:0] got);
        if (exp !== got) begin
            count_errs++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            flag_errs++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, got);
        end
    endtask

    task automatic check_line_num(input string name, input logic [line_w-1:0] exp,
                                  input logic [line_w-1:0] got);
        if (exp !== got) begin
            line_errs++;
            $display("ERR %0t %s expected %0d actual %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_phase(input string name, input scan_phase_e exp,
                               input scan_phase_e got);
        if (exp !== got) begin
            line_errs++;
            $display("ERR %0t %s expected %b actual %b", $time, name, exp, got);
        end
    endtask

    task automatic set_entry(input int c, input int i, input logic [7:0] y,
                             input logic [7:0] x, input logic [7:0] code,
                             input logic [7:0] attr);
        ent_tab[c][i] = {code, attr, y, x};
    endtask

    // Fill the case table, unused entries parked far below any visible line
    task automatic build_table();
        int c;
        int i;
        logic [7:0] ymask;
        seed = 96;
        case_tab[0] = {1'b1, 8'h00, 1'b0, 1'b0};   // Byte order and ordering
        case_tab[1] = {1'b1, 8'h00, 1'b0, 1'b0};   // Overflow
        case_tab[2] = {1'b1, 8'hF0, 1'b0, 1'b0};   // Offset with wrap
        case_tab[3] = {1'b0, 8'h00, 1'b0, 1'b0};   // Disabled
        case_tab[4] = {1'b1, 8'h00, 1'b1, 1'b0};   // Writes while scanning
        case_tab[5] = {1'b1, 8'h00, 1'b0, 1'b1};
        case_tab[6] = {1'b1, 8'hD3, 1'b0, 1'b1};
        case_tab[7] = {1'b1, 8'h00, 1'b0, 1'b1};
        for (c = 0; c < n_case; c++) begin
            for (i = 0; i < 32; i++)
                set_entry(c, i, 8'h80, 8'(i), 8'(i + 64), 8'h00);
        end
        // Distinct bytes per field, attr bits 6..4 must not leak
        set_entry(0, 0, 8'd4, 8'h11, 8'h22, 8'h85);
        set_entry(0, 3, 8'd12, 8'h3C, 8'hC3, 8'hF6);
        set_entry(0, 7, 8'd30, 8'hA0, 8'h5C, 8'h0F);
        set_entry(0, 12, 8'd10, 8'h33, 8'h44, 8'h7A);
        set_entry(0, 31, 8'd40, 8'hFE, 8'h01, 8'h83);
        for (i = 0; i < 12; i++)
            set_entry(1, 2 * i, 8'd8, 8'(16 * i), 8'(i + 1), 8'(i));   // 12 on lines 8..23
        set_entry(1, 25, 8'd26, 8'h55, 8'h99, 8'h81);
        set_entry(2, 1, 8'hF8, 8'h10, 8'h20, 8'h02);     // Lines 8..23
        set_entry(2, 9, 8'd4, 8'h30, 8'h40, 8'h84);      // Lines 20..35
        set_entry(2, 20, 8'hEC, 8'h50, 8'h60, 8'h06);    // Lines 0..11
        for (i = 0; i < 32; i++)
            ent_tab[3][i] = ent_tab[0][i];
        set_entry(4, 5, 8'd16, 8'h77, 8'h88, 8'h96);
        set_entry(4, 17, 8'd0, 8'h09, 8'hE1, 8'h8C);
        for (c = 5; c < n_case; c++) begin
            ymask = (case_tab[c].y_off == 8'h00) ? 8'h3F : 8'hFF;   // Crowd the top
            for (i = 0; i < 32; i++)
                set_entry(c, i, 8'($random(seed)) & ymask, 8'($random(seed)),
                          8'($random(seed)), 8'($random(seed)));
        end
    endtask

    task automatic cpu_write(input logic [7:0] addr, input logic [7:0] data);
        @(negedge clk);
        cpu_addr = addr;
        cpu_data = data;
        cpu_we   = 1'b1;
        @(negedge clk);
        cpu_we   = 1'b0;
    endtask

    task automatic write_entry(input int i, input obj_attr_t e);
        logic [7:0] base;
        base = 8'(4 * i);
        cpu_write(base, e.x);                 // Offset 0
        cpu_write(base + 8'd1, e.y);
        cpu_write(base + 8'd2, e.code);
        cpu_write(base + 8'd3, e.attr);
    endtask

    task automatic wait_vblank();
        int n;
        n = 0;
        while (phase != vblank && n < 2 * frame_clks) begin
            @(negedge clk);
            n++;
        end
        if (phase != vblank) begin
            timed_out = 1'b1;
            $display("Timeout while waiting for vertical blank");
        end
    endtask

    // Returns on the negedge where line 0 has just begun
    task automatic wait_frame_start();
        int n;
        bit found;
        n = 0;
        found = 1'b0;
        while (!found && n < 2 * frame_clks) begin
            @(negedge clk);
            n++;
            found = line_start_seen();
        end
        if (!found) begin
            timed_out = 1'b1;
            $display("Timeout while waiting for the first line of a frame");
        end
    endtask

    function automatic bit line_start_seen();
        return u_obj_top.line_start && line == 8'd0;
    endfunction

    // Expected hits of line l from the vertical range rule
    task automatic model_line(input int c, input int l);
        int i;
        obj_attr_t e;
        obj_hit_t h;
        logic [7:0] d;
        exp_q.delete();
        exp_ovf = 1'b0;
        for (i = 0; i < 32; i++) begin
            e = ent_tab[c][i];
            d = l + case_tab[c].y_off - e.y;  // Mod 256
            if (case_tab[c].en && d < obj_h) begin
                if (exp_q.size() < max_per_line) begin
                    h.code   = e.code;
                    h.row    = d[3:0];
                    h.x      = e.x;
                    h.flip   = e.attr[7];
                    h.colour = e.attr[3:0];
                    h.index  = 5'(i);
                    exp_q.push_back(h);
                end else begin
                    exp_ovf = 1'b1;
                end
            end
        end
    endtask

    task automatic check_line(input int c, input int l);
        int n;
        int t;
        int nxt;
        bit done;
        scan_phase_e exp_ph;
        model_line(c, l);
        n = 0;
        t = 0;
        done = 1'b0;
        while (!done && !timed_out) begin
            @(negedge clk);
            t++;
            if (hit_valid) begin
                if (n < exp_q.size())
                    check_hit($sformatf("hit[%0d] case %0d line %0d", n, c, l), exp_q[n], hit);
                else begin
                    hit_errs++;
                    $display("Unexpected extra hit for object %0d in case %0d line %0d",
                             hit.index, c, l);
                end
                n++;
            end
            if (u_obj_top.line_start)
                done = 1'b1;                  // Previous line is over
            else if (t > 2 * line_clks) begin
                timed_out = 1'b1;
                $display("Timeout while waiting for the end of line %0d", l);
            end
        end
        if (!timed_out) begin
            // Counter steps with line_start, blanking from line number
            nxt = (l + 1) % lines_per_frame;
            if (nxt >= vblank_start)
                exp_ph = vblank;
            else
                exp_ph = active;
            check_line_num($sformatf("line after line %0d", l), 8'(nxt), line);
            check_phase($sformatf("phase of line %0d", nxt), exp_ph, phase);
            check_count($sformatf("hits seen line %0d", l), 4'(exp_q.size()), 4'(n));
            check_count($sformatf("hit_count line %0d", l), 4'(exp_q.size()), hit_count);
            check_flag($sformatf("overflow line %0d", l), exp_ovf, overflow);
            @(negedge clk);
            check_flag("overflow after line_start", 1'b0, overflow);
            check_flag("hit_valid after line_start", 1'b0, hit_valid);
        end
    endtask

    initial begin
        int c;
        int i;
        cpu_addr   = 8'h00;
        cpu_data   = 8'h00;
        cpu_we     = 1'b0;
        rst        = 1'b1;
        hit_errs   = 0;
        count_errs = 0;
        flag_errs  = 0;
        line_errs  = 0;
        timed_out  = 1'b0;
        build_table();
        repeat (3) @(negedge clk);
        rst = 1'b0;
        c = 0;
        while (c < n_case && !timed_out) begin
            wait_vblank();
            if (!timed_out) begin
                cpu_write(8'h80, {7'd0, case_tab[c].en});
                cpu_write(8'h81, case_tab[c].y_off);
                for (i = 0; i < 32; i++)
                    write_entry(i, ent_tab[c][i]);
                wait_frame_start();
            end
            if (!timed_out && case_tab[c].active_wr) begin
                for (i = 0; i < 32; i++)
                    write_entry(i, ~ent_tab[c][i]);    // Must be dropped
                wait_frame_start();
            end
            for (i = 0; i < vblank_start && !timed_out; i++)
                check_line(c, i);
            c++;
        end
        $display("Errors: %0d hit, %0d count, %0d flag, %0d line, %0d timeout",
                 hit_errs, count_errs, flag_errs, line_errs, timed_out);
        if (!timed_out && hit_errs + count_errs + flag_errs + line_errs == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/obj_pkg.sv
hw/obj_timing.sv
hw/obj_ram.sv
hw/obj_attr_fetch.sv
hw/obj_ctrl_regs.sv
hw/obj_line_match.sv
hw/obj_top.sv
tb/obj_tb.sv

// ==== Bender.yml ====
package:
  name: obj_subsystem

sources:
  # Design, package first
  - files:
      - hw/obj_pkg.sv
      - hw/obj_timing.sv
      - hw/obj_ram.sv
      - hw/obj_attr_fetch.sv
      - hw/obj_ctrl_regs.sv
      - hw/obj_line_match.sv
      - hw/obj_top.sv

  # Simulation only, top module obj_tb
  - target: test
    files:
      - tb/obj_tb.sv
